// File: la_mmu_consts.svh
`ifndef LA_MMU_CONSTS_SVH
`define LA_MMU_CONSTS_SVH

// tlb geometry
`define TLB_ENTRIES 8
`define TLB_IDX_W   3

// CRMD fields
`define CRMD_PLV  1:0
`define CRMD_DA   3
`define CRMD_PG   4
`define CRMD_DATF 6:5

// DMW0/DMW1 fields
`define DMW_PLV0 0
`define DMW_PLV3 3
`define DMW_MAT  5:4
`define DMW_PSEG 27:25
`define DMW_VSEG 31:29

`endif

// File: la_csr_pkg.sv
`default_nettype none

// CSR numbers and field types for the fetch translation path
package la_csr_pkg;

	// only the CSRs this slice implements
	typedef enum logic [13:0] {
		CSR_CRMD = 14'h000,
		CSR_ASID = 14'h018,
		CSR_DMW0 = 14'h180,
		CSR_DMW1 = 14'h181
	} csr_addr_e;

	// privilege level, 0 is kernel and 3 is user
	typedef logic [1:0] plv_t;

	// memory access type, 0 means strongly-ordered uncached
	typedef logic [1:0] mat_t;

	// address space id as held in ASID.ASID
	typedef logic [9:0] asid_t;

endpackage

`default_nettype wire

// File: la_mmu_pkg.sv
`default_nettype none

// translation mode and tlb storage format
package la_mmu_pkg;

	// how the fetch address was translated
	typedef enum logic [1:0] {
		MODE_DIRECT = 2'd0,
		MODE_DMW0   = 2'd1,
		MODE_DMW1   = 2'd2,
		MODE_PAGED  = 2'd3
	} xlate_mode_e;

	// one 4 KiB page per entry
	typedef struct packed {
		logic        e;
		logic [19:0] vpn;
		logic [9:0]  asid;
		logic        g;
		logic [19:0] ppn;
		logic        v;
		logic [1:0]  mat;
		logic [1:0]  plv;
	} tlb_entry_t;

endpackage

`default_nettype wire

// File: csr_translate_regs.sv
`default_nettype none

`include "la_mmu_consts.svh"

module csr_translate_regs import la_csr_pkg::*; (
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        csr_we_i,
	input  csr_addr_e   csr_waddr_i,
	input  logic [31:0] csr_wdata_i,
	output logic [31:0] crmd_o,
	output logic [9:0]  asid_o,
	output logic [31:0] dmw0_o,
	output logic [31:0] dmw1_o
);

	// direct address mode at PLV0, fetch as coherent cached
	localparam logic [31:0] CRMD_RST = 32'h0000_0028;

	logic [31:0] crmd_q;
	asid_t       asid_q;
	logic [31:0] dmw0_q;
	logic [31:0] dmw1_q;

	// keep only the implemented CRMD fields
	function automatic logic [31:0] crmd_wval(input logic [31:0] wdata);
		logic [31:0] val;
		val = '0;
		val[`CRMD_PLV]  = wdata[`CRMD_PLV];
		val[`CRMD_DA]   = wdata[`CRMD_DA];
		val[`CRMD_PG]   = wdata[`CRMD_PG];
		val[`CRMD_DATF] = wdata[`CRMD_DATF];
		return val;
	endfunction

	// same layout for both windows
	function automatic logic [31:0] dmw_wval(input logic [31:0] wdata);
		logic [31:0] val;
		val = '0;
		val[`DMW_PLV0] = wdata[`DMW_PLV0];
		val[`DMW_PLV3] = wdata[`DMW_PLV3];
		val[`DMW_MAT]  = wdata[`DMW_MAT];
		val[`DMW_PSEG] = wdata[`DMW_PSEG];
		val[`DMW_VSEG] = wdata[`DMW_VSEG];
		return val;
	endfunction

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			crmd_q <= CRMD_RST;
			asid_q <= '0;
			dmw0_q <= '0;
			dmw1_q <= '0;
		end else if (csr_we_i) begin
			case (csr_waddr_i)
				CSR_CRMD: crmd_q <= crmd_wval(csr_wdata_i);
				CSR_ASID: asid_q <= csr_wdata_i[9:0];
				CSR_DMW0: dmw0_q <= dmw_wval(csr_wdata_i);
				CSR_DMW1: dmw1_q <= dmw_wval(csr_wdata_i);
				default: ;
			endcase
		end
	end

	assign crmd_o = crmd_q;
	assign asid_o = asid_q;
	assign dmw0_o = dmw0_q;
	assign dmw1_o = dmw1_q;

endmodule

`default_nettype wire

// File: tlb_lookup.sv
`default_nettype none

`include "la_mmu_consts.svh"

module tlb_lookup import la_mmu_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n_i,
	// write port
	input  logic                  tlb_we_i,
	input  logic [`TLB_IDX_W-1:0] tlb_widx_i,
	input  logic [19:0]           tlb_vpn_i,
	input  logic [9:0]            tlb_asid_i,
	input  logic                  tlb_g_i,
	input  logic [19:0]           tlb_ppn_i,
	input  logic                  tlb_v_i,
	input  logic [1:0]            tlb_mat_i,
	input  logic [1:0]            tlb_plv_i,
	// lookup port
	input  logic [19:0]           lookup_vpn_i,
	input  logic [9:0]            asid_i,
	output logic                  hit_o,
	output logic [19:0]           ppn_o,
	output logic                  v_o,
	output logic [1:0]            mat_o,
	output logic [1:0]            plv_o
);

	tlb_entry_t              entries_q [`TLB_ENTRIES];
	tlb_entry_t              wr_entry;
	tlb_entry_t              hit_entry;
	logic [`TLB_ENTRIES-1:0] match;

	// a written entry always exists
	assign wr_entry = '{
		e:    1'b1,
		vpn:  tlb_vpn_i,
		asid: tlb_asid_i,
		g:    tlb_g_i,
		ppn:  tlb_ppn_i,
		v:    tlb_v_i,
		mat:  tlb_mat_i,
		plv:  tlb_plv_i
	};

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `TLB_ENTRIES; i++) begin
				entries_q[i] <= '0;
			end
		end else if (tlb_we_i) begin
			entries_q[tlb_widx_i] <= wr_entry;
		end
	end

	// parallel compare, global entries ignore asid
	always_comb begin
		for (int i = 0; i < `TLB_ENTRIES; i++) begin
			match[i] = entries_q[i].e
				&& (entries_q[i].vpn == lookup_vpn_i)
				&& (entries_q[i].g || (entries_q[i].asid == asid_i));
		end
	end

	// scan downwards so the lowest index ends up selected
	always_comb begin
		hit_entry = '0;
		for (int i = `TLB_ENTRIES - 1; i >= 0; i--) begin
			if (match[i]) begin
				hit_entry = entries_q[i];
			end
		end
	end

	assign hit_o = |match;
	assign ppn_o = hit_entry.ppn;
	assign v_o   = hit_entry.v;
	assign mat_o = hit_entry.mat;
	assign plv_o = hit_entry.plv;

endmodule

`default_nettype wire

// File: fetch_addr_xlate.sv
`default_nettype none

`include "la_mmu_consts.svh"

module fetch_addr_xlate
	import la_csr_pkg::*;
	import la_mmu_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        req_i,
	input  logic [31:0] vaddr_i,
	input  logic [31:0] crmd_i,
	input  logic [31:0] dmw0_i,
	input  logic [31:0] dmw1_i,
	input  logic        tlb_hit_i,
	input  logic [19:0] tlb_ppn_i,
	input  logic        tlb_v_i,
	input  logic [1:0]  tlb_mat_i,
	input  logic [1:0]  tlb_plv_i,
	output logic [19:0] lookup_vpn_o,
	output logic        resp_valid_o,
	output logic [31:0] paddr_o,
	output logic        uncached_o,
	output xlate_mode_e mode_o,
	output logic        tlb_refill_o,
	output logic        page_invalid_o,
	output logic        priv_fault_o
);

	plv_t        cur_plv;
	logic        dmw0_en;
	logic        dmw1_en;
	logic        paged;
	xlate_mode_e mode_d;
	logic [31:0] paddr_d;
	mat_t        mat_d;

	// window enabled for the current plv and segment equal
	function automatic logic dmw_match(input logic [31:0] dmw, input plv_t plv,
		input logic [2:0] vseg);
		return ((dmw[`DMW_PLV0] && (plv == 2'd0)) || (dmw[`DMW_PLV3] && (plv == 2'd3)))
			&& (vseg == dmw[`DMW_VSEG]);
	endfunction

	assign cur_plv      = crmd_i[`CRMD_PLV];
	assign lookup_vpn_o = vaddr_i[31:12];
	assign dmw0_en      = crmd_i[`CRMD_PG] && dmw_match(dmw0_i, cur_plv, vaddr_i[31:29]);
	assign dmw1_en      = crmd_i[`CRMD_PG] && dmw_match(dmw1_i, cur_plv, vaddr_i[31:29]);

	always_comb begin
		if (crmd_i[`CRMD_DA]) begin
			mode_d  = MODE_DIRECT;
			paddr_d = vaddr_i;
			mat_d   = crmd_i[`CRMD_DATF];
		end else if (dmw0_en) begin
			mode_d  = MODE_DMW0;
			paddr_d = {dmw0_i[`DMW_PSEG], vaddr_i[28:0]};
			mat_d   = dmw0_i[`DMW_MAT];
		end else if (dmw1_en) begin
			mode_d  = MODE_DMW1;
			paddr_d = {dmw1_i[`DMW_PSEG], vaddr_i[28:0]};
			mat_d   = dmw1_i[`DMW_MAT];
		end else begin
			mode_d  = MODE_PAGED;
			paddr_d = tlb_hit_i ? {tlb_ppn_i, vaddr_i[11:0]} : 32'h0;
			mat_d   = tlb_mat_i;
		end
	end

	assign paged = (mode_d == MODE_PAGED);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			resp_valid_o   <= 1'b0;
			paddr_o        <= '0;
			uncached_o     <= 1'b0;
			mode_o         <= MODE_DIRECT;
			tlb_refill_o   <= 1'b0;
			page_invalid_o <= 1'b0;
			priv_fault_o   <= 1'b0;
		end else begin
			resp_valid_o <= req_i;
			if (req_i) begin
				paddr_o        <= paddr_d;
				uncached_o     <= (mat_d == 2'b00);
				mode_o         <= mode_d;
				tlb_refill_o   <= paged && !tlb_hit_i;
				page_invalid_o <= paged && tlb_hit_i && !tlb_v_i;
				priv_fault_o   <= paged && tlb_hit_i && tlb_v_i && (cur_plv > tlb_plv_i);
			end
		end
	end

endmodule

`default_nettype wire

// File: immu_top.sv
`default_nettype none

`include "la_mmu_consts.svh"

module immu_top
	import la_csr_pkg::*;
	import la_mmu_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  csr_we_i,
	input  csr_addr_e             csr_waddr_i,
	input  logic [31:0]           csr_wdata_i,
	input  logic                  tlb_we_i,
	input  logic [`TLB_IDX_W-1:0] tlb_widx_i,
	input  logic [19:0]           tlb_vpn_i,
	input  logic [9:0]            tlb_asid_i,
	input  logic                  tlb_g_i,
	input  logic [19:0]           tlb_ppn_i,
	input  logic                  tlb_v_i,
	input  logic [1:0]            tlb_mat_i,
	input  logic [1:0]            tlb_plv_i,
	input  logic                  req_i,
	input  logic [31:0]           vaddr_i,
	output logic                  resp_valid_o,
	output logic [31:0]           paddr_o,
	output logic                  uncached_o,
	output xlate_mode_e           mode_o,
	output logic                  tlb_refill_o,
	output logic                  page_invalid_o,
	output logic                  priv_fault_o
);

	logic [31:0] crmd;
	logic [9:0]  asid;
	logic [31:0] dmw0;
	logic [31:0] dmw1;
	logic [19:0] lookup_vpn;
	logic        hit;
	logic [19:0] hit_ppn;
	logic        hit_v;
	logic [1:0]  hit_mat;
	logic [1:0]  hit_plv;

	csr_translate_regs u_csr (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.csr_we_i    (csr_we_i),
		.csr_waddr_i (csr_waddr_i),
		.csr_wdata_i (csr_wdata_i),
		.crmd_o      (crmd),
		.asid_o      (asid),
		.dmw0_o      (dmw0),
		.dmw1_o      (dmw1)
	);

	tlb_lookup u_tlb (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.tlb_we_i     (tlb_we_i),
		.tlb_widx_i   (tlb_widx_i),
		.tlb_vpn_i    (tlb_vpn_i),
		.tlb_asid_i   (tlb_asid_i),
		.tlb_g_i      (tlb_g_i),
		.tlb_ppn_i    (tlb_ppn_i),
		.tlb_v_i      (tlb_v_i),
		.tlb_mat_i    (tlb_mat_i),
		.tlb_plv_i    (tlb_plv_i),
		.lookup_vpn_i (lookup_vpn),
		.asid_i       (asid),
		.hit_o        (hit),
		.ppn_o        (hit_ppn),
		.v_o          (hit_v),
		.mat_o        (hit_mat),
		.plv_o        (hit_plv)
	);

	fetch_addr_xlate u_xlate (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.req_i          (req_i),
		.vaddr_i        (vaddr_i),
		.crmd_i         (crmd),
		.dmw0_i         (dmw0),
		.dmw1_i         (dmw1),
		.tlb_hit_i      (hit),
		.tlb_ppn_i      (hit_ppn),
		.tlb_v_i        (hit_v),
		.tlb_mat_i      (hit_mat),
		.tlb_plv_i      (hit_plv),
		.lookup_vpn_o   (lookup_vpn),
		.resp_valid_o   (resp_valid_o),
		.paddr_o        (paddr_o),
		.uncached_o     (uncached_o),
		.mode_o         (mode_o),
		.tlb_refill_o   (tlb_refill_o),
		.page_invalid_o (page_invalid_o),
		.priv_fault_o   (priv_fault_o)
	);

endmodule

`default_nettype wire

// File: tb_immu_top.sv
`default_nettype none

`include "la_mmu_consts.svh"

module tb_immu_top
	import la_csr_pkg::*;
	import la_mmu_pkg::*;
();

	localparam logic [1:0] K_CSR = 2'd0;
	localparam logic [1:0] K_TLB = 2'd1;
	localparam logic [1:0] K_REQ = 2'd2;

	// one stimulus row, data doubles as vaddr and addr as tlb index
	typedef struct packed {
		logic [1:0]  kind;
		logic [13:0] addr;
		logic [31:0] data;
		logic [19:0] vpn;
		logic [9:0]  asid;
		logic        g;
		logic [19:0] ppn;
		logic        v;
		logic [1:0]  mat;
		logic [1:0]  plv;
		logic [31:0] paddr;
		logic        unc;
		logic [1:0]  mode;
		logic        refill;
		logic        inval;
		logic        priv;
	} row_t;

	logic                  clk;
	logic                  arst_n_i;
	logic                  csr_we_i;
	csr_addr_e             csr_waddr_i;
	logic [31:0]           csr_wdata_i;
	logic                  tlb_we_i;
	logic [`TLB_IDX_W-1:0] tlb_widx_i;
	logic [19:0]           tlb_vpn_i;
	logic [9:0]            tlb_asid_i;
	logic                  tlb_g_i;
	logic [19:0]           tlb_ppn_i;
	logic                  tlb_v_i;
	logic [1:0]            tlb_mat_i;
	logic [1:0]            tlb_plv_i;
	logic                  req_i;
	logic [31:0]           vaddr_i;
	logic                  resp_valid_o;
	logic [31:0]           paddr_o;
	logic                  uncached_o;
	xlate_mode_e           mode_o;
	logic                  tlb_refill_o;
	logic                  page_invalid_o;
	logic                  priv_fault_o;

	row_t        tbl [$];
	logic        tbl_ready;
	logic        pend;
	logic        nxt_pend;
	row_t        exp_row;
	row_t        nxt_row;
	int unsigned seed_val;

	immu_top u_dut (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.csr_we_i       (csr_we_i),
		.csr_waddr_i    (csr_waddr_i),
		.csr_wdata_i    (csr_wdata_i),
		.tlb_we_i       (tlb_we_i),
		.tlb_widx_i     (tlb_widx_i),
		.tlb_vpn_i      (tlb_vpn_i),
		.tlb_asid_i     (tlb_asid_i),
		.tlb_g_i        (tlb_g_i),
		.tlb_ppn_i      (tlb_ppn_i),
		.tlb_v_i        (tlb_v_i),
		.tlb_mat_i      (tlb_mat_i),
		.tlb_plv_i      (tlb_plv_i),
		.req_i          (req_i),
		.vaddr_i        (vaddr_i),
		.resp_valid_o   (resp_valid_o),
		.paddr_o        (paddr_o),
		.uncached_o     (uncached_o),
		.mode_o         (mode_o),
		.tlb_refill_o   (tlb_refill_o),
		.page_invalid_o (page_invalid_o),
		.priv_fault_o   (priv_fault_o)
	);

	always #50 clk = ~clk;

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic add_csr(input csr_addr_e addr, input logic [31:0] data);
		row_t r;
		r = '0;
		r.kind = K_CSR;
		r.addr = addr;
		r.data = data;
		tbl.push_back(r);
	endtask

	task automatic add_tlb(input int idx, input logic [19:0] vpn, input logic [9:0] asid,
		input logic g, input logic [19:0] ppn, input logic v, input logic [1:0] mat,
		input logic [1:0] plv);
		row_t r;
		r = '0;
		r.kind = K_TLB;
		r.addr = 14'(idx);
		r.vpn = vpn;
		r.asid = asid;
		r.g = g;
		r.ppn = ppn;
		r.v = v;
		r.mat = mat;
		r.plv = plv;
		tbl.push_back(r);
	endtask

	// vaddr and paddr are page aligned, the offset is added at run time
	task automatic add_req(input logic [31:0] vaddr, input logic [31:0] paddr, input logic unc,
		input xlate_mode_e mode, input logic refill, input logic inval, input logic priv);
		row_t r;
		r = '0;
		r.kind = K_REQ;
		r.data = vaddr;
		r.paddr = paddr;
		r.unc = unc;
		r.mode = mode;
		r.refill = refill;
		r.inval = inval;
		r.priv = priv;
		tbl.push_back(r);
	endtask

	task automatic fill_table();
		// reset state is direct mode with DATF 1
		add_req(32'h1234_5000, 32'h1234_5000, 1'b0, MODE_DIRECT, 1'b0, 1'b0, 1'b0);
		add_csr(CSR_CRMD, 32'h0000_0008);
		add_req(32'h8765_4000, 32'h8765_4000, 1'b1, MODE_DIRECT, 1'b0, 1'b0, 1'b0);
		// dmw0 seg 4 to 1 at plv0 uncached, dmw1 seg 5 to 2 at plv3 cached
		add_csr(CSR_DMW0, 32'h8200_0001);
		add_csr(CSR_DMW1, 32'ha400_0018);
		add_csr(CSR_ASID, 32'h0000_0005);
		add_tlb(0, 20'h00400, 10'd5, 1'b0, 20'h12345, 1'b1, 2'd1, 2'd3);
		add_tlb(1, 20'h00401, 10'd7, 1'b1, 20'h0abcd, 1'b1, 2'd0, 2'd3);
		add_tlb(2, 20'h00402, 10'd7, 1'b0, 20'h11111, 1'b1, 2'd1, 2'd3);
		add_tlb(3, 20'h00403, 10'd5, 1'b0, 20'h22222, 1'b0, 2'd1, 2'd3);
		add_tlb(4, 20'h00404, 10'd5, 1'b0, 20'h33333, 1'b1, 2'd1, 2'd0);
		// duplicate of entry 0, must lose against the lower index
		add_tlb(5, 20'h00400, 10'd5, 1'b0, 20'h44444, 1'b1, 2'd1, 2'd3);
		add_csr(CSR_CRMD, 32'h0000_0010);
		add_req(32'h8123_4000, 32'h2123_4000, 1'b1, MODE_DMW0, 1'b0, 1'b0, 1'b0);
		add_req(32'ha000_1000, 32'h0, 1'b0, MODE_PAGED, 1'b1, 1'b0, 1'b0);
		add_req(32'h0040_0000, 32'h1234_5000, 1'b0, MODE_PAGED, 1'b0, 1'b0, 1'b0);
		add_req(32'h0040_1000, 32'h0abc_d000, 1'b1, MODE_PAGED, 1'b0, 1'b0, 1'b0);
		add_req(32'h0040_2000, 32'h0, 1'b0, MODE_PAGED, 1'b1, 1'b0, 1'b0);
		add_req(32'h0040_3000, 32'h2222_2000, 1'b0, MODE_PAGED, 1'b0, 1'b1, 1'b0);
		add_req(32'h0040_4000, 32'h3333_3000, 1'b0, MODE_PAGED, 1'b0, 1'b0, 1'b0);
		add_csr(CSR_CRMD, 32'h0000_0013);
		add_req(32'h0040_4000, 32'h3333_3000, 1'b0, MODE_PAGED, 1'b0, 1'b0, 1'b1);
		add_req(32'ha000_2000, 32'h4000_2000, 1'b0, MODE_DMW1, 1'b0, 1'b0, 1'b0);
		add_req(32'h8000_3000, 32'h0, 1'b0, MODE_PAGED, 1'b1, 1'b0, 1'b0);
		// dmw1 now covers seg 4 too, at both plv0 and plv3
		add_csr(CSR_DMW1, 32'h8600_0019);
		add_req(32'h8000_5000, 32'h6000_5000, 1'b0, MODE_DMW1, 1'b0, 1'b0, 1'b0);
		add_csr(CSR_CRMD, 32'h0000_0010);
		add_req(32'h8000_6000, 32'h2000_6000, 1'b1, MODE_DMW0, 1'b0, 1'b0, 1'b0);
		add_csr(CSR_ASID, 32'h0000_0007);
		add_req(32'h0040_2000, 32'h1111_1000, 1'b0, MODE_PAGED, 1'b0, 1'b0, 1'b0);
		add_req(32'h0040_0000, 32'h0, 1'b0, MODE_PAGED, 1'b1, 1'b0, 1'b0);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] off;
		csr_we_i <= 1'b0;
		tlb_we_i <= 1'b0;
		req_i    <= 1'b0;
		nxt_pend = 1'b0;
		case (r.kind)
			K_CSR: begin
				csr_we_i    <= 1'b1;
				csr_waddr_i <= csr_addr_e'(r.addr);
				csr_wdata_i <= r.data;
			end
			K_TLB: begin
				tlb_we_i   <= 1'b1;
				tlb_widx_i <= r.addr[`TLB_IDX_W-1:0];
				tlb_vpn_i  <= r.vpn;
				tlb_asid_i <= r.asid;
				tlb_g_i    <= r.g;
				tlb_ppn_i  <= r.ppn;
				tlb_v_i    <= r.v;
				tlb_mat_i  <= r.mat;
				tlb_plv_i  <= r.plv;
			end
			K_REQ: begin
				off = $urandom & 32'h0000_0fff;
				req_i   <= 1'b1;
				vaddr_i <= r.data | off;
				nxt_row = r;
				// page offset passes through every mode, a miss gives 0
				nxt_row.paddr = r.refill ? 32'h0 : (r.paddr | off);
				nxt_pend = 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic check_pending();
		check_val("resp_valid_o", resp_valid_o, pend);
		if (pend) begin
			check_val("paddr_o", paddr_o, exp_row.paddr);
			check_val("mode_o", {30'b0, mode_o}, {30'b0, exp_row.mode});
			check_val("tlb_refill_o", tlb_refill_o, exp_row.refill);
			check_val("page_invalid_o", page_invalid_o, exp_row.inval);
			check_val("priv_fault_o", priv_fault_o, exp_row.priv);
			// no cache attribute exists on a refill
			if (!exp_row.refill) begin
				check_val("uncached_o", uncached_o, exp_row.unc);
			end
		end
	endtask

	initial begin
		wait (tbl_ready === 1'b1);
		#((tbl.size() * 10 + 4) * 100);
		$display("timeout: the test table did not finish in time");
		$display("Simulation failed");
		$fatal(1);
	end

	initial begin
		clk         = 1'b0;
		arst_n_i    = 1'b0;
		csr_we_i    = 1'b0;
		csr_waddr_i = CSR_CRMD;
		csr_wdata_i = '0;
		tlb_we_i    = 1'b0;
		tlb_widx_i  = '0;
		tlb_vpn_i   = '0;
		tlb_asid_i  = '0;
		tlb_g_i     = 1'b0;
		tlb_ppn_i   = '0;
		tlb_v_i     = 1'b0;
		tlb_mat_i   = '0;
		tlb_plv_i   = '0;
		req_i       = 1'b0;
		vaddr_i     = '0;
		pend        = 1'b0;
		nxt_pend    = 1'b0;
		exp_row     = '0;
		nxt_row     = '0;
		tbl_ready   = 1'b0;
		seed_val    = $urandom(32'h49df_6200);
		fill_table();
		tbl_ready = 1'b1;
		repeat (4) @(posedge clk);
		arst_n_i <= 1'b1;
		// one row per cycle, results checked one cycle later
		for (int i = 0; i < tbl.size(); i++) begin
			@(posedge clk);
			apply_row(tbl[i]);
			@(negedge clk);
			check_pending();
			pend = nxt_pend;
			exp_row = nxt_row;
		end
		@(posedge clk);
		csr_we_i <= 1'b0;
		tlb_we_i <= 1'b0;
		req_i    <= 1'b0;
		@(negedge clk);
		check_pending();
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
la_csr_pkg.sv
la_mmu_pkg.sv
csr_translate_regs.sv
tlb_lookup.sv
fetch_addr_xlate.sv
immu_top.sv
tb_immu_top.sv

// File: Bender.yml
package:
  name: immu_top

sources:
  - include_dirs:
      - .
    files:
      - la_csr_pkg.sv
      - la_mmu_pkg.sv
      - csr_translate_regs.sv
      - tlb_lookup.sv
      - fetch_addr_xlate.sv
      - immu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_immu_top.sv
